//--- core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath width, also used for addresses
`define CORE_XLEN       32

// Architectural register file
`define CORE_NREGS      32
`define CORE_REG_IDX_W  5

// First fetch address out of reset
`define CORE_RESET_PC   32'h0000_0000

`endif

//--- rv_isa_pkg.sv
`include "core_cfg.svh"

package rv_isa_pkg;

    // ----------------------------------------
    // Encodings
    // ----------------------------------------

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_IMM,  // LUI
        ALU_ADD_PC     // AUIPC
    } alu_op_e;

    // funct3 of loads and stores
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } mem_size_e;

    // funct3 of conditional branches
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_cond_e;

    // ----------------------------------------
    // Stage payloads
    // ----------------------------------------

    typedef struct packed {
        opcode_e                    opcode;
        logic [2:0]                 funct3;
        logic [`CORE_REG_IDX_W-1:0] rd;
        logic [`CORE_REG_IDX_W-1:0] rs1;
        logic [`CORE_REG_IDX_W-1:0] rs2;
        logic [`CORE_XLEN-1:0]      imm;
        alu_op_e                    alu_op;
        logic                       writes_rd;
        logic                       is_load;
        logic                       is_store;
    } decoded_instr_t;

    typedef struct packed {
        decoded_instr_t        dec;
        logic [`CORE_XLEN-1:0] result;      // ALU result or effective address
        logic [`CORE_XLEN-1:0] store_data;  // Raw rs2, not yet lane packed
    } ex_mem_t;

endpackage

//--- mem_bus_pkg.sv
`include "core_cfg.svh"

package mem_bus_pkg;

    // Request held stable by the requester until the response arrives
    typedef struct packed {
        logic                    valid;
        logic [`CORE_XLEN-1:0]   addr;
        logic [`CORE_XLEN-1:0]   data;
        logic [`CORE_XLEN/8-1:0] do_read;   // Byte lanes to read
        logic [`CORE_XLEN/8-1:0] do_write;  // Byte lanes to write
    } mem_req_t;

    // One-cycle response, data ignored for writes
    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] data;
    } mem_rsp_t;

endpackage

//--- reg_file.sv
`include "core_cfg.svh"

module reg_file (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`CORE_REG_IDX_W-1:0] rs1_addr,
    input  logic [`CORE_REG_IDX_W-1:0] rs2_addr,
    input  logic [`CORE_REG_IDX_W-1:0] rd_addr,
    input  logic                       rd_we,
    input  logic [`CORE_XLEN-1:0]      rd_data,
    output logic [`CORE_XLEN-1:0]      rs1_data,
    output logic [`CORE_XLEN-1:0]      rs2_data
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_addr != '0) begin  // x0 never written
            regs[rd_addr] <= rd_data;
        end
    end

    // x0 reads as zero regardless of array contents
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- decoder.sv
`include "core_cfg.svh"

module decoder (
    input  logic [`CORE_XLEN-1:0]      instr,
    output rv_isa_pkg::decoded_instr_t dec
);

    // Shared mapping for OP and OP-IMM, sub only exists in OP
    function automatic rv_isa_pkg::alu_op_e alu_from_funct(
        input logic [2:0] funct3,
        input logic       alt,
        input logic       sub_allowed
    );
        case (funct3)
            3'b000:  return (alt && sub_allowed) ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
            3'b001:  return rv_isa_pkg::ALU_SLL;
            3'b010:  return rv_isa_pkg::ALU_SLT;
            3'b011:  return rv_isa_pkg::ALU_SLTU;
            3'b100:  return rv_isa_pkg::ALU_XOR;
            3'b101:  return alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
            3'b110:  return rv_isa_pkg::ALU_OR;
            default: return rv_isa_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        dec        = '0;  // Unknown opcodes leave every flag clear
        dec.opcode = rv_isa_pkg::opcode_e'(instr[6:0]);
        dec.funct3 = instr[14:12];
        dec.rd     = instr[11:7];
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];
        dec.alu_op = rv_isa_pkg::ALU_ADD;

        case (dec.opcode)
            rv_isa_pkg::OP: begin
                dec.alu_op    = alu_from_funct(instr[14:12], instr[30], 1'b1);
                dec.writes_rd = 1'b1;
            end
            rv_isa_pkg::OP_IMM: begin
                dec.imm       = {{20{instr[31]}}, instr[31:20]};
                dec.alu_op    = alu_from_funct(instr[14:12], instr[30], 1'b0);
                dec.writes_rd = 1'b1;
            end
            rv_isa_pkg::LUI: begin
                dec.imm       = {instr[31:12], 12'b0};
                dec.alu_op    = rv_isa_pkg::ALU_PASS_IMM;
                dec.writes_rd = 1'b1;
            end
            rv_isa_pkg::AUIPC: begin
                dec.imm       = {instr[31:12], 12'b0};
                dec.alu_op    = rv_isa_pkg::ALU_ADD_PC;
                dec.writes_rd = 1'b1;
            end
            rv_isa_pkg::BRANCH: begin
                // B-type offset, bit 0 always zero
                dec.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
            end
            rv_isa_pkg::LOAD: begin
                dec.imm       = {{20{instr[31]}}, instr[31:20]};
                dec.writes_rd = 1'b1;
                dec.is_load   = 1'b1;
            end
            rv_isa_pkg::STORE: begin
                dec.imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};  // S-type split
                dec.is_store = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- alu.sv
`include "core_cfg.svh"

module alu (
    input  rv_isa_pkg::decoded_instr_t dec,
    input  logic [`CORE_XLEN-1:0]      pc,
    input  logic [`CORE_XLEN-1:0]      rs1_val,
    input  logic [`CORE_XLEN-1:0]      rs2_val,
    output logic [`CORE_XLEN-1:0]      result,
    output logic                       branch_taken
);

    logic [`CORE_XLEN-1:0] op_b;
    logic [4:0]            shamt;
    logic                  is_equal;
    logic                  lt_signed;
    logic                  lt_unsigned;

    // Register operand for OP and branch compares, immediate otherwise
    assign op_b = (dec.opcode == rv_isa_pkg::OP || dec.opcode == rv_isa_pkg::BRANCH)
                  ? rs2_val : dec.imm;
    assign shamt = op_b[4:0];

    assign is_equal    = (rs1_val == op_b);
    assign lt_signed   = ($signed(rs1_val) < $signed(op_b));
    assign lt_unsigned = (rs1_val < op_b);

    // ----------------------------------------
    // Arithmetic and logic
    // ----------------------------------------

    always_comb begin
        case (dec.alu_op)
            rv_isa_pkg::ALU_ADD:      result = rs1_val + op_b;  // Also load/store address
            rv_isa_pkg::ALU_SUB:      result = rs1_val - op_b;
            rv_isa_pkg::ALU_SLL:      result = rs1_val << shamt;
            rv_isa_pkg::ALU_SLT:      result = {{(`CORE_XLEN-1){1'b0}}, lt_signed};
            rv_isa_pkg::ALU_SLTU:     result = {{(`CORE_XLEN-1){1'b0}}, lt_unsigned};
            rv_isa_pkg::ALU_XOR:      result = rs1_val ^ op_b;
            rv_isa_pkg::ALU_SRL:      result = rs1_val >> shamt;
            rv_isa_pkg::ALU_SRA:      result = $signed(rs1_val) >>> shamt;
            rv_isa_pkg::ALU_OR:       result = rs1_val | op_b;
            rv_isa_pkg::ALU_AND:      result = rs1_val & op_b;
            rv_isa_pkg::ALU_PASS_IMM: result = dec.imm;
            rv_isa_pkg::ALU_ADD_PC:   result = pc + dec.imm;
            default:                  result = '0;
        endcase
    end

    // ----------------------------------------
    // Branch decision
    // ----------------------------------------

    always_comb begin
        branch_taken = 1'b0;
        if (dec.opcode == rv_isa_pkg::BRANCH) begin
            case (dec.funct3)
                rv_isa_pkg::BR_EQ:  branch_taken = is_equal;
                rv_isa_pkg::BR_NE:  branch_taken = !is_equal;
                rv_isa_pkg::BR_LT:  branch_taken = lt_signed;
                rv_isa_pkg::BR_GE:  branch_taken = !lt_signed;
                rv_isa_pkg::BR_LTU: branch_taken = lt_unsigned;
                rv_isa_pkg::BR_GEU: branch_taken = !lt_unsigned;
                default:            branch_taken = 1'b0;  // Reserved encodings fall through
            endcase
        end
    end

endmodule

//--- lsu.sv
`include "core_cfg.svh"

module lsu (
    input  logic                   in_mem_stage,
    input  rv_isa_pkg::ex_mem_t    stage,
    output mem_bus_pkg::mem_req_t  mem_req,
    input  mem_bus_pkg::mem_rsp_t  mem_rsp,
    output logic [`CORE_XLEN-1:0]  load_value,
    output logic                   needs_response
);

    logic [1:0]              offset;
    logic                    store_ok;
    logic [`CORE_XLEN/8-1:0] store_mask;
    logic [`CORE_XLEN-1:0]   store_word;
    logic [7:0]              rsp_byte;
    logic [15:0]             rsp_half;

    assign offset = stage.result[1:0];

    // Size the store data and mask at lane 0, then move both to the offset
    always_comb begin
        store_ok   = 1'b1;
        store_mask = '0;
        store_word = '0;
        case (stage.dec.funct3)
            rv_isa_pkg::MEM_B: begin
                store_mask = 4'b0001 << offset;
                store_word = {24'b0, stage.store_data[7:0]};
            end
            rv_isa_pkg::MEM_H: begin
                store_ok   = !offset[0];
                store_mask = 4'b0011 << offset;
                store_word = {16'b0, stage.store_data[15:0]};
            end
            rv_isa_pkg::MEM_W: begin
                store_ok   = (offset == 2'b00);
                store_mask = 4'b1111;
                store_word = stage.store_data;
            end
            default: store_ok = 1'b0;  // No such store width
        endcase
    end

    // ----------------------------------------
    // Request
    // ----------------------------------------

    always_comb begin
        mem_req        = '0;
        mem_req.addr   = stage.result;
        needs_response = 1'b0;
        if (in_mem_stage && stage.dec.is_load) begin
            mem_req.valid   = 1'b1;
            mem_req.do_read = '1;  // Whole word, lanes picked below
            needs_response  = 1'b1;
        end else if (in_mem_stage && stage.dec.is_store && store_ok) begin
            mem_req.valid    = 1'b1;
            mem_req.do_write = store_mask;
            mem_req.data     = store_word << {offset, 3'b000};
            needs_response   = 1'b1;
        end
    end

    // ----------------------------------------
    // Load extraction
    // ----------------------------------------

    assign rsp_byte = mem_rsp.data[{offset, 3'b000} +: 8];
    assign rsp_half = offset[1] ? mem_rsp.data[31:16] : mem_rsp.data[15:0];

    always_comb begin
        case (stage.dec.funct3)
            rv_isa_pkg::MEM_B:  load_value = {{24{rsp_byte[7]}}, rsp_byte};
            rv_isa_pkg::MEM_H:  load_value = {{16{rsp_half[15]}}, rsp_half};
            rv_isa_pkg::MEM_W:  load_value = mem_rsp.data;
            rv_isa_pkg::MEM_BU: load_value = {24'b0, rsp_byte};
            rv_isa_pkg::MEM_HU: load_value = {16'b0, rsp_half};
            default:            load_value = '0;
        endcase
    end

endmodule

//--- core.sv
`include "core_cfg.svh"

module core (
    input  logic                  clk,
    input  logic                  reset,
    output mem_bus_pkg::mem_req_t inst_mem_req,
    input  mem_bus_pkg::mem_rsp_t inst_mem_rsp,
    output mem_bus_pkg::mem_req_t data_mem_req,
    input  mem_bus_pkg::mem_rsp_t data_mem_rsp
);

    typedef enum logic [2:0] {
        STAGE_IDLE,     // Single cycle after reset, no requests
        STAGE_FETCH,
        STAGE_DECODE,
        STAGE_EXECUTE,
        STAGE_MEM,
        STAGE_WB
    } stage_e;

    stage_e                     stage_q;
    logic [`CORE_XLEN-1:0]      pc_q;
    logic [`CORE_XLEN-1:0]      instr_q;
    rv_isa_pkg::decoded_instr_t dec_q;
    rv_isa_pkg::ex_mem_t        ex_mem_q;
    logic [`CORE_XLEN-1:0]      wb_value_q;

    rv_isa_pkg::decoded_instr_t dec_next;
    logic [`CORE_XLEN-1:0]      rs1_val;
    logic [`CORE_XLEN-1:0]      rs2_val;
    logic [`CORE_XLEN-1:0]      alu_result;
    logic                       branch_taken;
    logic [`CORE_XLEN-1:0]      load_value;
    logic                       needs_response;
    logic                       rd_we;

    // ----------------------------------------
    // Stage sequencer and PC
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_q <= STAGE_IDLE;
            pc_q    <= `CORE_RESET_PC;
        end else begin
            case (stage_q)
                STAGE_IDLE:    stage_q <= STAGE_FETCH;
                STAGE_FETCH: begin
                    if (inst_mem_rsp.valid) stage_q <= STAGE_DECODE;
                end
                STAGE_DECODE:  stage_q <= STAGE_EXECUTE;
                STAGE_EXECUTE: begin
                    if (branch_taken) begin  // Skip mem and writeback entirely
                        pc_q    <= pc_q + dec_q.imm;
                        stage_q <= STAGE_FETCH;
                    end else begin
                        stage_q <= STAGE_MEM;
                    end
                end
                STAGE_MEM: begin
                    // Misaligned stores and ALU ops never wait here
                    if (!needs_response || data_mem_rsp.valid) stage_q <= STAGE_WB;
                end
                STAGE_WB: begin
                    pc_q    <= pc_q + 4;
                    stage_q <= STAGE_FETCH;
                end
                default: stage_q <= STAGE_IDLE;
            endcase
        end
    end

    // Stage payload registers
    always_ff @(posedge clk) begin
        if (stage_q == STAGE_FETCH && inst_mem_rsp.valid) begin
            instr_q <= inst_mem_rsp.data;
        end
        if (stage_q == STAGE_DECODE) begin
            dec_q <= dec_next;
        end
        if (stage_q == STAGE_EXECUTE) begin
            ex_mem_q.dec        <= dec_q;
            ex_mem_q.result     <= alu_result;
            ex_mem_q.store_data <= rs2_val;
        end
        if (stage_q == STAGE_MEM) begin
            wb_value_q <= ex_mem_q.dec.is_load ? load_value : ex_mem_q.result;
        end
    end

    // ----------------------------------------
    // Instruction fetch
    // ----------------------------------------

    always_comb begin
        inst_mem_req      = '0;
        inst_mem_req.addr = pc_q;
        if (stage_q == STAGE_FETCH) begin
            inst_mem_req.valid   = 1'b1;
            inst_mem_req.do_read = '1;
        end
    end

    // ----------------------------------------
    // Datapath
    // ----------------------------------------

    decoder decoder_i (
        .instr (instr_q),
        .dec   (dec_next)
    );

    assign rd_we = (stage_q == STAGE_WB) && ex_mem_q.dec.writes_rd;

    reg_file reg_file_i (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (dec_q.rs1),
        .rs2_addr (dec_q.rs2),
        .rd_addr  (ex_mem_q.dec.rd),
        .rd_we    (rd_we),
        .rd_data  (wb_value_q),
        .rs1_data (rs1_val),
        .rs2_data (rs2_val)
    );

    alu alu_i (
        .dec          (dec_q),
        .pc           (pc_q),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    lsu lsu_i (
        .in_mem_stage   (stage_q == STAGE_MEM),
        .stage          (ex_mem_q),
        .mem_req        (data_mem_req),
        .mem_rsp        (data_mem_rsp),
        .load_value     (load_value),
        .needs_response (needs_response)
    );

endmodule

//--- tb_checker.sv
module tb_checker (
    input logic                  clk,
    input logic                  reset,
    input mem_bus_pkg::mem_req_t inst_mem_req,
    input mem_bus_pkg::mem_rsp_t inst_mem_rsp,
    input mem_bus_pkg::mem_req_t data_mem_req,
    input mem_bus_pkg::mem_rsp_t data_mem_rsp
);

    timeunit 1ns;
    timeprecision 1ps;

    // Expected data writes in program order
    string       exp_name [$];
    logic [31:0] exp_addr [$];
    logic [3:0]  exp_mask [$];
    logic [31:0] exp_data [$];

    int   value_errs = 0;
    int   other_errs = 0;
    logic inst_waiting = 1'b0;
    logic data_waiting = 1'b0;
    mem_bus_pkg::mem_req_t held_inst;
    mem_bus_pkg::mem_req_t held_data;

    task automatic expect_write(input string name, input logic [31:0] addr,
                                input logic [3:0] mask, input logic [31:0] data);
        exp_name.push_back(name);
        exp_addr.push_back(addr);
        exp_mask.push_back(mask);
        exp_data.push_back(data);
    endtask

    task automatic compare_write(input mem_bus_pkg::mem_req_t req);
        string       name;
        logic [31:0] addr;
        logic [3:0]  mask;
        logic [31:0] data;
        if (req.do_read != '0) begin
            other_errs++;
            $display("write request to %h also has read lanes set", req.addr);
        end
        if (exp_name.size() == 0) begin
            other_errs++;
            $display("unexpected write to %h with data %h", req.addr, req.data);
        end else begin
            name = exp_name.pop_front();
            addr = exp_addr.pop_front();
            mask = exp_mask.pop_front();
            data = exp_data.pop_front();
            if ({addr, mask, data} != {req.addr, req.do_write, req.data}) begin
                value_errs++;
                $display(
                    "error %s: expected addr %h mask %h data %h, actual addr %h mask %h data %h",
                    name, addr, mask, data, req.addr, req.do_write, req.data);
            end
        end
    endtask

    task automatic report_counts(output int values, output int others);
        others = other_errs;
        if (exp_name.size() != 0) begin
            $display("%0d expected writes never happened, first missing is %s",
                     exp_name.size(), exp_name[0]);
            others = other_errs + exp_name.size();
        end
        values = value_errs;
    endtask

    // ----------------------------------------
    // Bus monitors
    // ----------------------------------------

    always @(posedge clk) begin
        if (!reset) begin
            if (data_mem_req.valid) begin
                if (!data_waiting) begin  // First cycle of a new request
                    held_data    = data_mem_req;
                    data_waiting = 1'b1;
                    if (data_mem_req.do_write != '0) begin
                        compare_write(data_mem_req);
                    end else if (data_mem_req.do_read != 4'hF) begin
                        other_errs++;
                        $display("load request to %h does not read the whole word",
                                 data_mem_req.addr);
                    end
                end else if (data_mem_req != held_data) begin
                    other_errs++;
                    $display("data request changed while waiting for its response");
                end
            end
            if (data_mem_rsp.valid) data_waiting = 1'b0;

            if (inst_mem_req.valid) begin
                if (!inst_waiting) begin
                    held_inst    = inst_mem_req;
                    inst_waiting = 1'b1;
                    if (inst_mem_req.do_read != 4'hF || inst_mem_req.do_write != '0) begin
                        other_errs++;
                        $display("instruction fetch from %h is not a plain word read",
                                 inst_mem_req.addr);
                    end
                end else if (inst_mem_req != held_inst) begin
                    other_errs++;
                    $display("instruction request changed while waiting for its response");
                end
            end
            if (inst_mem_rsp.valid) inst_waiting = 1'b0;
        end
    end

endmodule

//--- tb_core.sv
module tb_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          MAX_CYCLES = 20000;
    localparam logic [31:0] NOP        = 32'h0000_0013;
    localparam logic [6:0]  OPI        = 7'b0010011;
    localparam logic [6:0]  LD         = 7'b0000011;
    localparam logic [6:0]  LUI        = 7'b0110111;

    logic clk;
    logic reset = 1'b1;
    mem_bus_pkg::mem_req_t inst_mem_req;
    mem_bus_pkg::mem_req_t data_mem_req;
    mem_bus_pkg::mem_rsp_t inst_mem_rsp = '0;
    mem_bus_pkg::mem_rsp_t data_mem_rsp = '0;

    logic [31:0] imem [256];
    logic [7:0]  dmem [4096];

    // Test table with three instruction slots per row
    string       row_name [$];
    logic [31:0] row_ins  [$];
    logic        row_has  [$];
    logic [31:0] row_addr [$];
    logic [3:0]  row_mask [$];
    logic [31:0] row_data [$];

    logic        inst_busy = 1'b0;
    logic        data_busy = 1'b0;
    int          inst_wait;
    int          data_wait;
    int          base;
    logic [31:0] end_pc;
    logic        timed_out;
    int          value_errs;
    int          other_errs;

    core dut_i (
        .clk          (clk),
        .reset        (reset),
        .inst_mem_req (inst_mem_req),
        .inst_mem_rsp (inst_mem_rsp),
        .data_mem_req (data_mem_req),
        .data_mem_rsp (data_mem_rsp)
    );

    tb_checker check_i (
        .clk          (clk),
        .reset        (reset),
        .inst_mem_req (inst_mem_req),
        .inst_mem_rsp (inst_mem_rsp),
        .data_mem_req (data_mem_req),
        .data_mem_rsp (data_mem_rsp)
    );

    // ----------------------------------------
    // Instruction encoders
    // ----------------------------------------

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {f7, rs2, rs1, f3, 5'd3, 7'b0110011};  // Result always in x3
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};  // Base is x0
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3);
        // Compares x1 with x2 and jumps 8 bytes over the next slot
        return {1'b0, 6'b0, 5'd2, 5'd1, f3, 4'b0100, 1'b0, 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    task automatic add_row(input string name, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] c, input logic has, input logic [11:0] addr,
                           input logic [3:0] mask, input logic [31:0] data);
        row_name.push_back(name);
        row_ins.push_back(a);
        row_ins.push_back(b);
        row_ins.push_back(c);
        row_has.push_back(has);
        row_addr.push_back({20'b0, addr});
        row_mask.push_back(mask);
        row_data.push_back(data);
    endtask

    // Operation into x3, then store x3 as a full word
    task automatic alu_row(input string name, input logic [31:0] instr,
                           input logic [11:0] addr, input logic [31:0] data);
        add_row(name, instr, s_type(addr, 5'd3, 3'b010), NOP, 1'b1, addr, 4'hF, data);
    endtask

    task automatic build_table();
        // AUIPC sits at address 4
        add_row("auipc", NOP, u_type(20'h00001, 5'd3, 7'b0010111), s_type(12'h200, 5'd3, 3'b010),
                1'b1, 12'h200, 4'hF, 32'h0000_1004);
        add_row("operands", i_type(12'hFEC, 5'd0, 3'b000, 5'd1, OPI),
                i_type(12'h003, 5'd0, 3'b000, 5'd2, OPI), s_type(12'h204, 5'd1, 3'b010),
                1'b1, 12'h204, 4'hF, 32'hFFFF_FFEC);
        // x1 = -20, x2 = 3
        alu_row("add",   r_type(7'h00, 5'd2, 5'd1, 3'b000), 12'h208, 32'hFFFF_FFEF);
        alu_row("sub",   r_type(7'h20, 5'd2, 5'd1, 3'b000), 12'h20C, 32'hFFFF_FFE9);
        alu_row("sll",   r_type(7'h00, 5'd2, 5'd1, 3'b001), 12'h210, 32'hFFFF_FF60);
        alu_row("slt",   r_type(7'h00, 5'd2, 5'd1, 3'b010), 12'h214, 32'h0000_0001);
        alu_row("sltu",  r_type(7'h00, 5'd2, 5'd1, 3'b011), 12'h218, 32'h0000_0000);
        alu_row("xor",   r_type(7'h00, 5'd2, 5'd1, 3'b100), 12'h21C, 32'hFFFF_FFEF);
        alu_row("srl",   r_type(7'h00, 5'd2, 5'd1, 3'b101), 12'h220, 32'h1FFF_FFFD);
        alu_row("sra",   r_type(7'h20, 5'd2, 5'd1, 3'b101), 12'h224, 32'hFFFF_FFFD);
        alu_row("or",    r_type(7'h00, 5'd2, 5'd1, 3'b110), 12'h228, 32'hFFFF_FFEF);
        alu_row("and",   r_type(7'h00, 5'd2, 5'd1, 3'b111), 12'h22C, 32'h0000_0000);
        alu_row("addi",  i_type(12'h005, 5'd1, 3'b000, 5'd3, OPI), 12'h230, 32'hFFFF_FFF1);
        alu_row("slti",  i_type(12'hFEB, 5'd1, 3'b010, 5'd3, OPI), 12'h234, 32'h0000_0000);
        alu_row("sltiu", i_type(12'hFFF, 5'd1, 3'b011, 5'd3, OPI), 12'h238, 32'h0000_0001);
        alu_row("xori",  i_type(12'h0FF, 5'd1, 3'b100, 5'd3, OPI), 12'h23C, 32'hFFFF_FF13);
        alu_row("ori",   i_type(12'h00F, 5'd1, 3'b110, 5'd3, OPI), 12'h240, 32'hFFFF_FFEF);
        alu_row("andi",  i_type(12'h07F, 5'd1, 3'b111, 5'd3, OPI), 12'h244, 32'h0000_006C);
        alu_row("slli",  i_type(12'h004, 5'd1, 3'b001, 5'd3, OPI), 12'h248, 32'hFFFF_FEC0);
        alu_row("srli",  i_type(12'h01C, 5'd1, 3'b101, 5'd3, OPI), 12'h24C, 32'h0000_000F);
        alu_row("srai",  i_type(12'h402, 5'd1, 3'b101, 5'd3, OPI), 12'h250, 32'hFFFF_FFFB);
        alu_row("lui",   u_type(20'h12345, 5'd3, LUI), 12'h254, 32'h1234_5000);
        add_row("x0", i_type(12'h005, 5'd0, 3'b000, 5'd0, OPI), s_type(12'h258, 5'd0, 3'b010),
                NOP, 1'b1, 12'h258, 4'hF, 32'h0);

        // Store lanes with x4 = 0x11223344
        add_row("sw", u_type(20'h11223, 5'd4, LUI), i_type(12'h344, 5'd4, 3'b000, 5'd4, OPI),
                s_type(12'h300, 5'd4, 3'b010), 1'b1, 12'h300, 4'hF, 32'h1122_3344);
        add_row("sb0", s_type(12'h310, 5'd4, 3'b000), NOP, NOP,
                1'b1, 12'h310, 4'h1, 32'h0000_0044);
        add_row("sb1", s_type(12'h311, 5'd4, 3'b000), NOP, NOP,
                1'b1, 12'h311, 4'h2, 32'h0000_4400);
        add_row("sb2", s_type(12'h312, 5'd4, 3'b000), NOP, NOP,
                1'b1, 12'h312, 4'h4, 32'h0044_0000);
        add_row("sb3", s_type(12'h313, 5'd4, 3'b000), NOP, NOP,
                1'b1, 12'h313, 4'h8, 32'h4400_0000);
        add_row("sh0", s_type(12'h320, 5'd4, 3'b001), NOP, NOP,
                1'b1, 12'h320, 4'h3, 32'h0000_3344);
        add_row("sh2", s_type(12'h322, 5'd4, 3'b001), NOP, NOP,
                1'b1, 12'h322, 4'hC, 32'h3344_0000);
        add_row("sw_misaligned", s_type(12'h331, 5'd4, 3'b010), NOP, NOP,
                1'b0, 12'h0, 4'h0, 32'h0);

        // Loads from 0x8091A7F3 at 0x340
        add_row("ld_word", u_type(20'h8091A, 5'd5, LUI), i_type(12'h7F3, 5'd5, 3'b000, 5'd5, OPI),
                s_type(12'h340, 5'd5, 3'b010), 1'b1, 12'h340, 4'hF, 32'h8091_A7F3);
        alu_row("lb0",  i_type(12'h340, 5'd0, 3'b000, 5'd3, LD), 12'h350, 32'hFFFF_FFF3);
        alu_row("lbu1", i_type(12'h341, 5'd0, 3'b100, 5'd3, LD), 12'h354, 32'h0000_00A7);
        alu_row("lb3",  i_type(12'h343, 5'd0, 3'b000, 5'd3, LD), 12'h358, 32'hFFFF_FF80);
        alu_row("lbu2", i_type(12'h342, 5'd0, 3'b100, 5'd3, LD), 12'h35C, 32'h0000_0091);
        alu_row("lh0",  i_type(12'h340, 5'd0, 3'b001, 5'd3, LD), 12'h360, 32'hFFFF_A7F3);
        alu_row("lhu2", i_type(12'h342, 5'd0, 3'b101, 5'd3, LD), 12'h364, 32'h0000_8091);
        alu_row("lh2",  i_type(12'h342, 5'd0, 3'b001, 5'd3, LD), 12'h368, 32'hFFFF_8091);
        alu_row("lw",   i_type(12'h340, 5'd0, 3'b010, 5'd3, LD), 12'h36C, 32'h8091_A7F3);

        // Branches on x1 = -20 and x2 = 3 store their marker only when not taken
        add_row("beq",  b_type(3'b000), s_type(12'h380, 5'd2, 3'b010), NOP,
                1'b1, 12'h380, 4'hF, 32'd3);
        add_row("bne",  b_type(3'b001), s_type(12'h384, 5'd2, 3'b010), NOP,
                1'b0, 12'h384, 4'hF, 32'd3);
        add_row("blt",  b_type(3'b100), s_type(12'h388, 5'd2, 3'b010), NOP,
                1'b0, 12'h388, 4'hF, 32'd3);
        add_row("bge",  b_type(3'b101), s_type(12'h38C, 5'd2, 3'b010), NOP,
                1'b1, 12'h38C, 4'hF, 32'd3);
        add_row("bltu", b_type(3'b110), s_type(12'h390, 5'd2, 3'b010), NOP,
                1'b1, 12'h390, 4'hF, 32'd3);
        add_row("bgeu", b_type(3'b111), s_type(12'h394, 5'd2, 3'b010), NOP,
                1'b0, 12'h394, 4'hF, 32'd3);
    endtask

    // ----------------------------------------
    // Memory models
    // ----------------------------------------

    always @(negedge clk) begin
        inst_mem_rsp = '0;
        if (reset) begin
            inst_busy = 1'b0;
        end else if (inst_busy) begin
            inst_wait--;
            if (inst_wait == 0) begin
                inst_mem_rsp.valid = 1'b1;
                inst_mem_rsp.data  = imem[inst_mem_req.addr[9:2]];
                inst_busy          = 1'b0;
            end
        end else if (inst_mem_req.valid) begin
            inst_busy = 1'b1;
            inst_wait = 1 + int'($urandom % 4);
        end
    end

    always @(negedge clk) begin
        data_mem_rsp = '0;
        if (reset) begin
            data_busy = 1'b0;
        end else if (data_busy) begin
            data_wait--;
            if (data_wait == 0) begin
                base = int'({data_mem_req.addr[11:2], 2'b00});
                for (int l = 0; l < 4; l++) begin
                    if (data_mem_req.do_write[l]) dmem[base + l] = data_mem_req.data[8*l +: 8];
                end
                data_mem_rsp.valid = 1'b1;
                data_mem_rsp.data  = {dmem[base + 3], dmem[base + 2], dmem[base + 1], dmem[base]};
                data_busy          = 1'b0;
            end
        end else if (data_mem_req.valid) begin
            data_busy = 1'b1;
            data_wait = 1 + int'($urandom % 4);
        end
    end

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ----------------------------------------
    // Run
    // ----------------------------------------

    initial begin
        void'($urandom(49));
        for (int a = 0; a < 256; a++) begin
            imem[a] = NOP | (32'(a) << 20);  // addi x0, x0, a
        end
        for (int a = 0; a < 4096; a++) begin
            dmem[a] = 8'(a ^ (a >> 8));
        end
        build_table();
        for (int k = 0; k < row_name.size(); k++) begin
            for (int s = 0; s < 3; s++) begin
                imem[3*k + s] = row_ins[3*k + s];
            end
            if (row_has[k]) begin
                check_i.expect_write(row_name[k], row_addr[k], row_mask[k], row_data[k]);
            end
        end
        end_pc = 32'(12 * row_name.size());

        repeat (10) @(negedge clk);
        reset = 1'b0;

        // Program is done once the fetch past the last row goes out
        timed_out = 1'b1;
        for (int cyc = 0; cyc < MAX_CYCLES; cyc++) begin
            @(negedge clk);
            if (inst_mem_req.valid && inst_mem_req.addr == end_pc) begin
                timed_out = 1'b0;
                break;
            end
        end
        if (timed_out) $display("timeout: the program never reached its end address");

        check_i.report_counts(value_errs, other_errs);
        other_errs = other_errs + int'(timed_out);
        $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+.
rv_isa_pkg.sv
mem_bus_pkg.sv
reg_file.sv
decoder.sv
alu.sv
lsu.sv
core.sv
tb_checker.sv
tb_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f project.f --top-module tb_core -o tb_core_sim
./obj_dir/tb_core_sim > sim.log
cat sim.log

if grep -q "^Test OK$" sim.log; then
    exit 0
fi
exit 1
